// ==== project.f ====
+incdir+include
design/dcache_pkg.sv
design/cache_ram.sv
design/tag_decode.sv
design/miss_control.sv
design/line_update.sv
design/dcache_top.sv
verif/mem_responder.sv
verif/dcache_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= dcache_tb
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verif/dcache_tb.sv ====
`timescale 1ns/1ps

module dcache_tb;
    import dcache_pkg::*;

    localparam int N_DIR = 8;
    localparam int N_RAND = 400;
    // write-back plus refill, both at the longest responder delay
    localparam int MISS_CYCLES = 48;
    localparam int WATCHDOG_NS = (N_RAND + 2 * N_DIR + 16) * MISS_CYCLES * 100;

    typedef struct packed {
        cpu_req_t    req;
        logic [31:0] cycle;
    } pend_t;

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic        req_valid = 1'b0;
    cpu_req_t    cpu_req = '0;
    logic [3:0]  resp_delay = 4'd0;
    logic        ready;
    logic        data_ok;
    word_t       rdata;
    mem_req_t    mem_req;
    mem_rsp_t    mem_rsp;

    logic [7:0]  model [8192];
    pend_t       pending[$];
    logic [31:0] rng = 32'he133;
    addr_t       last_addr = '0;
    int          errors = 0;
    int          cycle = 0;
    int          last_lat = 0;
    int          accept_cnt = 0;
    int          done_cnt = 0;

    always #50 clk = ~clk;

    dcache_top dut_i (
        .clk        (clk),
        .rst        (rst),
        .req_valid_i(req_valid),
        .req_i      (cpu_req),
        .ready_o    (ready),
        .data_ok_o  (data_ok),
        .rdata_o    (rdata),
        .mem_req_o  (mem_req),
        .mem_rsp_i  (mem_rsp)
    );

    mem_responder u_mem (
        .clk      (clk),
        .rst      (rst),
        .delay_i  (resp_delay),
        .mem_req_i(mem_req),
        .mem_rsp_o(mem_rsp)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // four tags over two sets, so two ways keep getting evicted
    function automatic addr_t cached_addr(input logic [31:0] r);
        return {20'b0, r[1:0], 5'b0, r[2], r[6:3]};
    endfunction

    function automatic addr_t uncached_addr(input logic [31:0] r);
        return {19'b0, 1'b1, 4'b0000, r[7:0]};
    endfunction

    function automatic strb_t make_strb(input logic [1:0] size, input logic [1:0] ofs);
        case (size)
            2'd0: return strb_t'(4'b0001 << ofs);
            2'd1: return ofs[1] ? 4'b1100 : 4'b0011;
            default: return 4'b1111;
        endcase
    endfunction

    // one strobe bit per byte of the line, set only inside the addressed word
    function automatic logic [15:0] lane_strb(input addr_t a, input strb_t s);
        logic [15:0] m;
        m = '0;
        for (int b = 0; b < 4; b++) begin
            m[{a[3:2], 2'(b)}] = s[b];
        end
        return m;
    endfunction

    function automatic word_t model_word(input addr_t a);
        word_t       w;
        logic [12:0] idx;
        for (int b = 0; b < 4; b++) begin
            idx = {a[12:2], 2'b00} + 13'(b);
            w[b*8 +: 8] = model[idx];
        end
        return w;
    endfunction

    function automatic line_t model_line(input addr_t a);
        line_t       l;
        logic [12:0] idx;
        for (int b = 0; b < 16; b++) begin
            idx = {a[12:4], 4'b0000} + 13'(b);
            l[b*8 +: 8] = model[idx];
        end
        return l;
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_line(input string name, input line_t got, input line_t exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // stores reach the model when they complete, loads see every older store
    task automatic complete_request();
        pend_t       e;
        logic [12:0] idx;
        e = pending.pop_front();
        if (e.req.wstrb == '0) begin
            check_word("rdata_o", rdata, model_word(e.req.addr));
            last_lat = cycle - int'(e.cycle);
        end else begin
            for (int b = 0; b < 4; b++) begin
                idx = {e.req.addr[12:2], 2'b00} + 13'(b);
                if (e.req.wstrb[b]) begin
                    model[idx] = e.req.wdata[b*8 +: 8];
                end
            end
        end
    endtask

    task automatic check_mem_request();
        pend_t e;
        if (pending.size() == 0) begin
            errors++;
            $display("memory access at %0t with no request outstanding", $time);
        end else begin
            e = pending[0];
            check_word("mem_req_o.uncached", word_t'(mem_req.uncached), word_t'(e.req.uncached));
            if (mem_req.uncached) begin
                check_word("mem_req_o.addr", mem_req.addr, {e.req.addr[31:2], 2'b00});
                if (mem_req.wr) begin
                    check_word("mem_req_o.wstrb16", word_t'(mem_req.wstrb16),
                               word_t'(lane_strb(e.req.addr, e.req.wstrb)));
                end
            end else if (mem_req.rd) begin
                check_word("mem_req_o.addr", mem_req.addr, {e.req.addr[31:4], 4'b0000});
            end else begin
                // dirty victim leaves with the bytes of all completed stores
                check_line("mem_req_o.wline", mem_req.wline, model_line(mem_req.addr));
            end
        end
    endtask

    task automatic send(input cpu_req_t r);
        req_valid <= 1'b1;
        cpu_req <= r;
        @(posedge clk);
        while (!ready) begin
            @(posedge clk);
        end
    endtask

    task automatic wait_idle();
        req_valid <= 1'b0;
        do begin
            @(negedge clk);
        end while (pending.size() != 0);
        @(posedge clk);
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            if (data_ok) begin
                done_cnt++;
                if (pending.size() == 0) begin
                    errors++;
                    $display("data_ok_o pulsed at %0t with no request outstanding", $time);
                end else begin
                    complete_request();
                end
            end
            if (mem_req.rd || mem_req.wr) begin
                check_mem_request();
            end
            if (req_valid && ready) begin
                pending.push_back({cpu_req, 32'(cycle)});
                accept_cnt++;
            end
            cycle++;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout after %0d ns with %0d requests outstanding", WATCHDOG_NS,
                 pending.size());
        $display("Finished with errors");
        $finish;
    end

    initial begin : stimulus
        cpu_req_t    r;
        logic [31:0] ctl;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_word("ready_o", word_t'(ready), 32'd1);
        check_word("data_ok_o", word_t'(data_ok), 32'd0);
        check_word("mem_req_o.rd", word_t'(mem_req.rd), 32'd0);
        check_word("mem_req_o.wr", word_t'(mem_req.wr), 32'd0);
        for (int a = 0; a < 8192; a++) begin
            model[13'(a)] = u_mem.mem[13'(a)];
        end
        @(posedge clk);

        // second load of a line on an idle cache is a plain hit
        for (int n = 0; n < N_DIR; n++) begin
            rng = xorshift(rng);
            r = '0;
            r.addr = cached_addr(rng);
            resp_delay <= rng[19:16];
            send(r);
            wait_idle();
            send(r);
            wait_idle();
            check_word("data_ok_o latency", word_t'(last_lat), 32'd2);
        end

        for (int n = 0; n < N_RAND; n++) begin
            rng = xorshift(rng);
            ctl = rng;
            rng = xorshift(rng);
            r = '0;
            r.wdata = rng;
            r.addr = cached_addr(ctl);
            case (ctl[10:8])
                3'd0: begin
                    r.uncached = 1'b1;
                    r.addr = uncached_addr(ctl);
                    if (ctl[11]) begin
                        r.wstrb = make_strb(ctl[13:12], r.addr[1:0]);
                    end
                end
                3'd1, 3'd2, 3'd3: r.wstrb = make_strb(ctl[13:12], r.addr[1:0]);
                // read back the word touched last
                3'd4, 3'd5: r.addr = last_addr;
                default: ;
            endcase
            if (!r.uncached) begin
                last_addr = r.addr;
            end
            resp_delay <= ctl[19:16];
            send(r);
            req_valid <= 1'b0;
            if (ctl[21:20] == 2'd0) begin
                repeat (int'(ctl[23:22])) @(posedge clk);
            end
        end

        wait_idle();
        check_word("data_ok_o count", word_t'(done_cnt), word_t'(accept_cnt));
        $display("error count: %0d in testbench checks, %0d in memory responder",
                 errors, u_mem.errors);
        if (errors == 0 && u_mem.errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== verif/mem_responder.sv ====
`timescale 1ns/1ps

module mem_responder (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [3:0]           delay_i,
    input  dcache_pkg::mem_req_t mem_req_i,
    output dcache_pkg::mem_rsp_t mem_rsp_o
);
    import dcache_pkg::*;

    logic [7:0]  mem [8192];
    int          errors = 0;
    mem_rsp_t    rsp = '0;
    logic        pending;
    logic        is_rd;
    addr_t       base;
    logic [3:0]  wait_cnt;

    assign mem_rsp_o = rsp;

    function automatic line_t read_line(input addr_t a);
        line_t       l;
        logic [12:0] idx;
        for (int b = 0; b < 16; b++) begin
            idx = a[12:0] + 13'(b);
            l[b*8 +: 8] = mem[idx];
        end
        return l;
    endfunction

    task automatic write_line(input addr_t a, input line_t l, input logic [15:0] strb);
        logic [12:0] idx;
        for (int b = 0; b < 16; b++) begin
            idx = a[12:0] + 13'(b);
            if (strb[b]) begin
                mem[idx] = l[b*8 +: 8];
            end
        end
    endtask

    // contents depend on every address bit so aliasing shows up
    initial begin
        for (int a = 0; a < 8192; a++) begin
            mem[13'(a)] = 8'(a * 37) ^ 8'(a >> 8);
        end
    end

    always @(posedge clk) begin
        rsp <= '0;
        if (rst) begin
            pending <= 1'b0;
        end else if (mem_req_i.rd || mem_req_i.wr) begin
            if (pending) begin
                errors++;
                $display("memory request at %0t while another access is outstanding", $time);
            end
            pending <= 1'b1;
            is_rd <= mem_req_i.rd;
            base <= {mem_req_i.addr[31:4], 4'b0000};
            wait_cnt <= delay_i;
            // uncached strobes already sit on their word lane
            if (mem_req_i.wr) begin
                write_line({mem_req_i.addr[31:4], 4'b0000}, mem_req_i.wline, mem_req_i.wstrb16);
            end
        end else if (pending) begin
            if (wait_cnt == 4'd0) begin
                pending <= 1'b0;
                rsp.rvalid <= is_rd;
                rsp.bvalid <= !is_rd;
                rsp.rline <= read_line(base);
            end else begin
                wait_cnt <= wait_cnt - 4'd1;
            end
        end
    end

endmodule

// ==== design/dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req_valid_i,
    input  dcache_pkg::cpu_req_t req_i,
    output logic                 ready_o,
    output logic                 data_ok_o,
    output dcache_pkg::word_t    rdata_o,
    output dcache_pkg::mem_req_t mem_req_o,
    input  dcache_pkg::mem_rsp_t mem_rsp_i
);
    import dcache_pkg::*;

    stage_t                s3;
    logic                  busy;
    logic                  refill_done;
    logic                  miss;
    logic                  ram_ren;
    index_t                ram_raddr;
    way_t                  victim;
    ram_wr_t               ram_wr;
    tag_entry_t [NWAY-1:0] tag_rd;
    line_t [NWAY-1:0]      line_rd;

    tag_decode u_tag_decode (
        .clk          (clk),
        .rst          (rst),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .ready_o      (ready_o),
        .busy_i       (busy),
        .refill_done_i(refill_done),
        .ram_ren_o    (ram_ren),
        .ram_raddr_o  (ram_raddr),
        .tags_i       (tag_rd),
        .lines_i      (line_rd),
        .s3_o         (s3)
    );

    miss_control u_miss_control (
        .clk          (clk),
        .rst          (rst),
        .s3_i         (s3),
        .miss_i       (miss),
        .busy_o       (busy),
        .refill_done_o(refill_done),
        .victim_o     (victim),
        .mem_req_o    (mem_req_o),
        .mem_rsp_i    (mem_rsp_i)
    );

    // refill_done marks the cycle the refill line is on the memory port
    line_update u_line_update (
        .s3_i        (s3),
        .mem_rsp_i   (mem_rsp_i),
        .fill_state_i(refill_done),
        .victim_i    (victim),
        .miss_o      (miss),
        .ram_wr_o    (ram_wr),
        .data_ok_o   (data_ok_o),
        .rdata_o     (rdata_o)
    );

    for (genvar w = 0; w < NWAY; w++) begin : g_way
        cache_ram #(.payload_t(tag_entry_t)) u_tag_ram (
            .clk    (clk),
            .rst    (rst),
            .ren_i  (ram_ren),
            .raddr_i(ram_raddr),
            .waddr_i(ram_wr.index),
            .we_i   (ram_wr.we[w]),
            .wdata_i(ram_wr.tag),
            .rdata_o(tag_rd[w])
        );

        cache_ram #(.payload_t(line_t)) u_data_ram (
            .clk    (clk),
            .rst    (rst),
            .ren_i  (ram_ren),
            .raddr_i(ram_raddr),
            .waddr_i(ram_wr.index),
            .we_i   (ram_wr.we[w]),
            .wdata_i(ram_wr.line),
            .rdata_o(line_rd[w])
        );
    end

endmodule

// ==== design/line_update.sv ====
`timescale 1ns/1ps

module line_update (
    input  dcache_pkg::stage_t   s3_i,
    input  dcache_pkg::mem_rsp_t mem_rsp_i,
    input  logic                 fill_state_i,
    input  dcache_pkg::way_t     victim_i,
    output logic                 miss_o,
    output dcache_pkg::ram_wr_t  ram_wr_o,
    output logic                 data_ok_o,
    output dcache_pkg::word_t    rdata_o
);
    import dcache_pkg::*;

    logic [NWAY-1:0]  hit_way;
    logic             cached;
    logic             hit;
    logic             store;
    logic             uc_done;
    line_t            hit_line;
    line_t            src_line;
    tag_t             tag;
    logic [OFS_W-3:0] word_sel;

    // replace the strobed bytes of one word in a line
    function automatic line_t merge(
        input line_t            line,
        input logic [OFS_W-3:0] sel,
        input strb_t            strb,
        input word_t            data
    );
        line_t res;
        res = line;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[sel*32 + b*8 +: 8] = data[b*8 +: 8];
            end
        end
        return res;
    endfunction

    assign tag = s3_i.req.addr[ADDR_W-1 -: TAG_W];
    assign word_sel = s3_i.req.addr[OFS_W-1:2];
    assign store = (s3_i.req.wstrb != '0);
    assign cached = s3_i.valid && !s3_i.req.uncached;

    always_comb begin
        hit_way = '0;
        hit_line = '0;
        for (int w = 0; w < NWAY; w++) begin
            if (cached && s3_i.tags[w].valid && s3_i.tags[w].tag == tag) begin
                hit_way[w] = 1'b1;
                hit_line = s3_i.lines[w];
            end
        end
    end

    assign hit = |hit_way;
    assign miss_o = cached && !hit;
    assign uc_done = s3_i.valid && s3_i.req.uncached
                     && (mem_rsp_i.rvalid || mem_rsp_i.bvalid);

    // a store lands in the hit line or in the line coming back from memory
    assign src_line = fill_state_i ? mem_rsp_i.rline : hit_line;

    always_comb begin
        ram_wr_o = '0;
        ram_wr_o.index = s3_i.req.addr[OFS_W +: IDX_W];
        ram_wr_o.tag = '{dirty: store, valid: 1'b1, tag: tag};
        ram_wr_o.line = store ? merge(src_line, word_sel, s3_i.req.wstrb, s3_i.req.wdata)
                              : src_line;
        if (fill_state_i) begin
            ram_wr_o.we[victim_i] = 1'b1;
        end else if (hit && store) begin
            ram_wr_o.we = hit_way;
        end
    end

    always_comb begin
        data_ok_o = 1'b0;
        rdata_o = '0;
        if (hit) begin
            data_ok_o = 1'b1;
            rdata_o = hit_line[word_sel*32 +: 32];
        end else if (fill_state_i || uc_done) begin
            data_ok_o = 1'b1;
            rdata_o = mem_rsp_i.rline[word_sel*32 +: 32];
        end
    end

endmodule

// ==== design/miss_control.sv ====
`timescale 1ns/1ps
`include "dcache_config.svh"

module miss_control (
    input  logic                 clk,
    input  logic                 rst,
    input  dcache_pkg::stage_t   s3_i,
    input  logic                 miss_i,
    output logic                 busy_o,
    output logic                 refill_done_o,
    output dcache_pkg::way_t     victim_o,
    output dcache_pkg::mem_req_t mem_req_o,
    input  dcache_pkg::mem_rsp_t mem_rsp_i
);
    import dcache_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        WB_REQ,
        WB_WAIT,
        FILL_REQ,
        FILL_WAIT,
        UC_REQ,
        UC_WAIT
    } state_t;

    state_t      state;
    state_t      next_state;
    logic [15:0] lfsr;
    way_t        pick;
    way_t        victim_q;
    tag_entry_t  vtag;
    index_t      index;
    logic        uc_pending;
    logic        victim_dirty;

    assign index = s3_i.req.addr[OFS_W +: IDX_W];
    assign uc_pending = s3_i.valid && s3_i.req.uncached;
    assign pick = lfsr[WAY_W-1:0];

    // victim follows the lfsr while idle and is frozen once a miss starts
    assign victim_o = (state == IDLE) ? pick : victim_q;
    assign vtag = s3_i.tags[victim_o];
    assign victim_dirty = vtag.valid && vtag.dirty;

    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr <= `DC_LFSR_SEED;
        end else begin
            lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            victim_q <= pick;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (uc_pending) begin
                    next_state = UC_REQ;
                end else if (miss_i) begin
                    next_state = victim_dirty ? WB_REQ : FILL_REQ;
                end
            end
            WB_REQ: next_state = WB_WAIT;
            WB_WAIT: if (mem_rsp_i.bvalid) next_state = FILL_REQ;
            FILL_REQ: next_state = FILL_WAIT;
            FILL_WAIT: if (mem_rsp_i.rvalid) next_state = IDLE;
            UC_REQ: next_state = UC_WAIT;
            UC_WAIT: if (mem_rsp_i.rvalid || mem_rsp_i.bvalid) next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    // uncached completion lets the pipeline move on in the same cycle
    always_comb begin
        case (state)
            IDLE: busy_o = uc_pending || miss_i;
            UC_WAIT: busy_o = !(mem_rsp_i.rvalid || mem_rsp_i.bvalid);
            default: busy_o = 1'b1;
        endcase
    end

    assign refill_done_o = (state == FILL_WAIT) && mem_rsp_i.rvalid;

    always_comb begin
        mem_req_o = '0;
        case (state)
            WB_REQ: begin
                mem_req_o.wr = 1'b1;
                mem_req_o.addr = {vtag.tag, index, {OFS_W{1'b0}}};
                mem_req_o.wline = s3_i.lines[victim_o];
                mem_req_o.wstrb16 = '1;
            end
            FILL_REQ: begin
                mem_req_o.rd = 1'b1;
                mem_req_o.addr = {s3_i.req.addr[ADDR_W-1:OFS_W], {OFS_W{1'b0}}};
            end
            UC_REQ: begin
                mem_req_o.uncached = 1'b1;
                mem_req_o.rd = (s3_i.req.wstrb == '0);
                mem_req_o.wr = (s3_i.req.wstrb != '0);
                mem_req_o.addr = {s3_i.req.addr[ADDR_W-1:2], 2'b00};
                // data on every lane, strobe only on the addressed word
                mem_req_o.wline = {(LINE_BYTES / 4){s3_i.req.wdata}};
                mem_req_o.wstrb16 = LINE_BYTES'(s3_i.req.wstrb) << (4 * s3_i.req.addr[OFS_W-1:2]);
            end
            default: begin
                mem_req_o = '0;
            end
        endcase
    end

endmodule

// ==== design/tag_decode.sv ====
`timescale 1ns/1ps

module tag_decode (
    input  logic                                         clk,
    input  logic                                         rst,
    input  logic                                         req_valid_i,
    input  dcache_pkg::cpu_req_t                         req_i,
    output logic                                         ready_o,
    input  logic                                         busy_i,
    input  logic                                         refill_done_i,
    output logic                                         ram_ren_o,
    output dcache_pkg::index_t                           ram_raddr_o,
    input  dcache_pkg::tag_entry_t [dcache_pkg::NWAY-1:0] tags_i,
    input  dcache_pkg::line_t [dcache_pkg::NWAY-1:0]      lines_i,
    output dcache_pkg::stage_t                           s3_o
);
    import dcache_pkg::*;

    logic                  s2_valid;
    cpu_req_t              s2_req;
    logic                  s2_store;
    logic                  accept;
    logic                  s3_valid;
    cpu_req_t              s3_req;
    tag_entry_t [NWAY-1:0] s3_tags;
    line_t [NWAY-1:0]      s3_lines;

    assign s2_store = s2_valid && (s2_req.wstrb != '0);

    // one bubble after a store keeps stage 2 empty while stage 3 writes
    assign ready_o = !busy_i && !s2_store;
    assign accept = req_valid_i && ready_o;

    // on refill_done the held stage 2 request reads its set again
    assign ram_ren_o = accept || refill_done_i;
    assign ram_raddr_o = refill_done_i ? s2_req.addr[OFS_W +: IDX_W]
                                       : req_i.addr[OFS_W +: IDX_W];

    always_ff @(posedge clk) begin
        if (rst) begin
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
        end else if (!busy_i) begin
            s2_valid <= accept;
            s3_valid <= s2_valid;
        end else if (refill_done_i) begin
            // refilled request is answered this cycle
            s3_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy_i) begin
            s2_req <= req_i;
            s3_req <= s2_req;
            s3_tags <= tags_i;
            s3_lines <= lines_i;
        end
    end

    assign s3_o = '{valid: s3_valid, req: s3_req, tags: s3_tags, lines: s3_lines};

endmodule

// ==== design/cache_ram.sv ====
`timescale 1ns/1ps

module cache_ram #(
    parameter type payload_t = dcache_pkg::line_t
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               ren_i,
    input  dcache_pkg::index_t raddr_i,
    input  dcache_pkg::index_t waddr_i,
    input  logic               we_i,
    input  payload_t           wdata_i,
    output payload_t           rdata_o
);
    import dcache_pkg::*;

    payload_t mem [NSET];
    // sets never written since reset read back as all zero
    logic [NSET-1:0] written;

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            written <= '0;
        end else if (we_i) begin
            written[waddr_i] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ren_i) begin
            if (we_i && waddr_i == raddr_i) begin
                // write in the read cycle goes straight to the output
                rdata_o <= wdata_i;
            end else if (written[raddr_i]) begin
                rdata_o <= mem[raddr_i];
            end else begin
                rdata_o <= '0;
            end
        end
    end

endmodule

// ==== design/dcache_pkg.sv ====
`include "dcache_config.svh"

package dcache_pkg;

    localparam int NWAY = `DC_NWAY;
    localparam int NSET = `DC_NSET;
    localparam int LINE_BYTES = `DC_LINE_BYTES;
    localparam int ADDR_W = `DC_ADDR_W;
    localparam int OFS_W = $clog2(LINE_BYTES);
    localparam int IDX_W = $clog2(NSET);
    localparam int TAG_W = ADDR_W - IDX_W - OFS_W;
    localparam int WAY_W = (NWAY > 1) ? $clog2(NWAY) : 1;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [LINE_BYTES*8-1:0] line_t;
    typedef logic [3:0] strb_t;
    typedef logic [IDX_W-1:0] index_t;
    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [WAY_W-1:0] way_t;

    typedef struct packed {
        logic dirty;
        logic valid;
        tag_t tag;
    } tag_entry_t;

    // a zero wstrb is a load
    typedef struct packed {
        addr_t addr;
        strb_t wstrb;
        word_t wdata;
        logic  uncached;
    } cpu_req_t;

    typedef struct packed {
        logic                  valid;
        cpu_req_t              req;
        tag_entry_t [NWAY-1:0] tags;
        line_t [NWAY-1:0]      lines;
    } stage_t;

    typedef struct packed {
        logic                  rd;
        logic                  wr;
        logic                  uncached;
        addr_t                 addr;
        line_t                 wline;
        logic [LINE_BYTES-1:0] wstrb16;
    } mem_req_t;

    typedef struct packed {
        logic  rvalid;
        logic  bvalid;
        line_t rline;
    } mem_rsp_t;

    typedef struct packed {
        logic [NWAY-1:0] we;
        index_t          index;
        tag_entry_t      tag;
        line_t           line;
    } ram_wr_t;

endpackage

// ==== include/dcache_config.svh ====
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// cache geometry
`define DC_NWAY 2
`define DC_NSET 64
`define DC_LINE_BYTES 16
`define DC_ADDR_W 32

// the replacement lfsr starts here and must never be zero
`define DC_LFSR_SEED 16'hACE1

`endif
